// ==== ixDecodePkg.sv ====
/* Shared types and constants for the indexed-ALU pre-decoder.
   The credit width must hold OpCredits, and QueueDepth must be a power of two. */
`default_nettype none

package ixDecodePkg;

    // Queue and credit sizing.
    localparam int QueueDepth = 4;
    localparam int QueuePtrW  = 2;
    localparam int QueueCntW  = 3;
    localparam int OpCredits  = 2;
    localparam int CreditW    = 2;

    // Instruction byte and index prefixes.
    typedef logic [7:0] instrByte_t;

    localparam instrByte_t PrefixIx = 8'hDD;
    localparam instrByte_t PrefixIy = 8'hFD;

    typedef logic [QueuePtrW-1:0] queuePtr_t;
    typedef logic [QueueCntW-1:0] queueCnt_t;
    typedef logic [CreditW-1:0]   opCredit_t;

    // Code equals opcode bits 5:3.
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluAdc = 3'd1,
        aluSub = 3'd2,
        aluSbc = 3'd3,
        aluAnd = 3'd4,
        aluXor = 3'd5,
        aluOr  = 3'd6,
        aluCp  = 3'd7
    } aluOp_t;

    // Prefix history of the bytes already taken.
    typedef enum logic [1:0] {
        trkIdle     = 2'd0,
        trkPrefix   = 2'd1,
        trkPrefixed = 2'd2
    } trackState_t;

endpackage

`default_nettype wire

// ==== byteQueue.sv ====
/* Input FIFO with one credit pulse per pop, one cycle after the pop.
   The source must hold a credit to push; a push into a full queue is dropped. */
`timescale 1ns/1ps
`default_nettype none

module byteQueue (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   byteValid,
    input  ixDecodePkg::instrByte_t byteData,
    input  logic                   byteTake,
    output logic                   headValid,
    output ixDecodePkg::instrByte_t headByte,
    output logic                   byteCredit
);
    import ixDecodePkg::*;

    instrByte_t mem [QueueDepth];
    queuePtr_t  wrPtr;
    queuePtr_t  rdPtr;
    queueCnt_t  count;
    logic       full;
    logic       doPush;
    logic       doPop;

    assign full      = (count == queueCnt_t'(QueueDepth));
    assign doPush    = byteValid && !full;
    assign doPop     = byteTake && headValid;
    assign headValid = (count != '0);
    assign headByte  = mem[rdPtr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            byteCredit <= 1'b0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One slot freed per pop.
            byteCredit <= doPop;
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= byteData;
        end
    end

endmodule

`default_nettype wire

// ==== prefixTracker.sv ====
/* Tracks whether the last or second-to-last taken byte was DD/FD.
   A later prefix overrides an earlier one; a displacement always ends the sequence. */
`timescale 1ns/1ps
`default_nettype none

module prefixTracker (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    byteTake,
    input  logic                    dispTaken,
    input  ixDecodePkg::instrByte_t headByte,
    output ixDecodePkg::trackState_t trkState,
    output logic                    trkUseIy
);
    import ixDecodePkg::*;

    trackState_t stateNext;
    logic        useIyNext;
    logic        isPrefix;

    assign isPrefix = (headByte == PrefixIx) || (headByte == PrefixIy);

    always_comb begin
        stateNext = trkState;
        useIyNext = trkUseIy;
        if (byteTake) begin
            if (dispTaken) begin
                // Displacement is data, even if it looks like a prefix.
                stateNext = trkIdle;
            end else if (isPrefix) begin
                stateNext = trkPrefix;
                useIyNext = (headByte == PrefixIy);
            end else begin
                unique case (trkState)
                    trkPrefix: stateNext = trkPrefixed;
                    default:   stateNext = trkIdle;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            trkState <= trkIdle;
            trkUseIy <= 1'b0;
        end else begin
            trkState <= stateNext;
            trkUseIy <= useIyNext;
        end
    end

endmodule

`default_nettype wire

// ==== aluOpDecoder.sv ====
/* Flags the last taken byte as a 10xxx110 opcode and holds its ALU op.
   matchOp is only meaningful while opMatch is high. */
`timescale 1ns/1ps
`default_nettype none

module aluOpDecoder (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    byteTake,
    input  logic                    dispTaken,
    input  ixDecodePkg::instrByte_t headByte,
    output logic                    opMatch,
    output ixDecodePkg::aluOp_t     matchOp
);
    import ixDecodePkg::*;

    logic isAluByte;

    // ADD..CP against (index+d).
    assign isAluByte = (headByte[7:6] == 2'b10) && (headByte[2:0] == 3'b110);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opMatch <= 1'b0;
        end else if (byteTake) begin
            opMatch <= isAluByte && !dispTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (byteTake) begin
            matchOp <= aluOp_t'(headByte[5:3]);
        end
    end

endmodule

`default_nettype wire

// ==== opIssue.sv ====
/* Pops the queue, spots displacements and issues one registered op per sequence.
   A displacement stalls while no op credit is held; the rest of the stream waits behind it. */
`timescale 1ns/1ps
`default_nettype none

module opIssue (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     headValid,
    input  ixDecodePkg::instrByte_t  headByte,
    input  ixDecodePkg::trackState_t trkState,
    input  logic                     trkUseIy,
    input  logic                     opMatch,
    input  ixDecodePkg::aluOp_t      matchOp,
    input  logic                     opCredit,
    output logic                     byteTake,
    output logic                     dispTaken,
    output logic                     opValid,
    output ixDecodePkg::aluOp_t      opAlu,
    output logic                     opUseIy,
    output ixDecodePkg::instrByte_t  opDisp
);
    import ixDecodePkg::*;

    opCredit_t creditCnt;
    logic      headIsDisp;
    logic      stall;

    // Prefix two bytes back and an ALU opcode last: the head is d.
    assign headIsDisp = (trkState == trkPrefixed) && opMatch;
    assign stall      = headIsDisp && (creditCnt == '0);
    assign byteTake   = headValid && !stall;
    assign dispTaken  = byteTake && headIsDisp;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            creditCnt <= opCredit_t'(OpCredits);
        end else begin
            case ({dispTaken, opCredit})
                2'b10:   creditCnt <= creditCnt - 1'b1;
                2'b01:   creditCnt <= creditCnt + 1'b1;
                default: creditCnt <= creditCnt;
            endcase
        end
    end

    // Single-cycle pulse, one cycle after the displacement is taken.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opValid <= 1'b0;
        end else begin
            opValid <= dispTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (dispTaken) begin
            opAlu   <= matchOp;
            opUseIy <= trkUseIy;
            opDisp  <= headByte;
        end
    end

endmodule

`default_nettype wire

// ==== ixAluDecodeTop.sv ====
/* Indexed-ALU pre-decoder: DD/FD, 10xxx110, d in; one op out per sequence.
   Both sides use credits; the source starts with QueueDepth, the issue stage with OpCredits. */
`timescale 1ns/1ps
`default_nettype none

module ixAluDecodeTop (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    byteValid,
    input  ixDecodePkg::instrByte_t byteData,
    output logic                    byteCredit,
    output logic                    opValid,
    output ixDecodePkg::aluOp_t     opAlu,
    output logic                    opUseIy,
    output ixDecodePkg::instrByte_t opDisp,
    input  logic                    opCredit
);
    import ixDecodePkg::*;

    logic        headValid;
    instrByte_t  headByte;
    logic        byteTake;
    logic        dispTaken;
    trackState_t trkState;
    logic        trkUseIy;
    logic        opMatch;
    aluOp_t      matchOp;

    byteQueue byteQueue_inst (
        .clk        (clk),
        .rstN       (rstN),
        .byteValid  (byteValid),
        .byteData   (byteData),
        .byteTake   (byteTake),
        .headValid  (headValid),
        .headByte   (headByte),
        .byteCredit (byteCredit)
    );

    // Tracker and decoder see the same head byte in the same cycle.
    prefixTracker prefixTracker_inst (
        .clk       (clk),
        .rstN      (rstN),
        .byteTake  (byteTake),
        .dispTaken (dispTaken),
        .headByte  (headByte),
        .trkState  (trkState),
        .trkUseIy  (trkUseIy)
    );

    aluOpDecoder aluOpDecoder_inst (
        .clk       (clk),
        .rstN      (rstN),
        .byteTake  (byteTake),
        .dispTaken (dispTaken),
        .headByte  (headByte),
        .opMatch   (opMatch),
        .matchOp   (matchOp)
    );

    opIssue opIssue_inst (
        .clk       (clk),
        .rstN      (rstN),
        .headValid (headValid),
        .headByte  (headByte),
        .trkState  (trkState),
        .trkUseIy  (trkUseIy),
        .opMatch   (opMatch),
        .matchOp   (matchOp),
        .opCredit  (opCredit),
        .byteTake  (byteTake),
        .dispTaken (dispTaken),
        .opValid   (opValid),
        .opAlu     (opAlu),
        .opUseIy   (opUseIy),
        .opDisp    (opDisp)
    );

endmodule

`default_nettype wire

// ==== ixAluDecodeTb_asserts.sv ====
/* Bound to ixAluDecodeTop; mirrors queue occupancy and op credits from its own signals. */
`timescale 1ns/1ps
`default_nettype none

module ixAluDecodeTb_asserts (
    input logic clk,
    input logic rstN,
    input logic byteValid,
    input logic byteTake,
    input logic headValid,
    input logic byteCredit,
    input logic opValid,
    input logic opCredit
);
    import ixDecodePkg::*;

    int   occupancy;
    int   credits;
    logic pop;

    assign pop = byteTake && headValid;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            occupancy <= 0;
            credits   <= OpCredits;
        end else begin
            occupancy <= occupancy + int'(byteValid) - int'(pop);
            credits   <= credits + int'(opCredit) - int'(opValid);
        end
    end

    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        byteValid |-> occupancy < QueueDepth) else $error("push into a full byte queue");

    noOpWithoutCredit: assert property (@(posedge clk) disable iff (!rstN)
        opValid |-> credits > 0) else $error("op issued with no op credit");

    singleCyclePulse: assert property (@(posedge clk) disable iff (!rstN)
        opValid |=> !opValid) else $error("opValid high for two cycles");

    creditAfterPop: assert property (@(posedge clk) disable iff (!rstN)
        pop |=> byteCredit) else $error("pop without a byte credit");

    popBeforeCredit: assert property (@(posedge clk) disable iff (!rstN)
        byteCredit |-> $past(pop)) else $error("byte credit without a pop");

endmodule

bind ixAluDecodeTop ixAluDecodeTb_asserts ixAluDecodeTb_asserts_inst (
    .clk        (clk),
    .rstN       (rstN),
    .byteValid  (byteValid),
    .byteTake   (byteTake),
    .headValid  (headValid),
    .byteCredit (byteCredit),
    .opValid    (opValid),
    .opCredit   (opCredit)
);

`default_nettype wire

// ==== ixAluDecodeTb.sv ====
/* Stimulus and expected ops come from ixAluDecode_testdata.txt in the project root.
   Op credits are only returned for ops already seen, so the DUT counter cannot overflow. */
`timescale 1ns/1ps
`default_nettype none

module ixAluDecodeTb;
    import ixDecodePkg::*;

    localparam int WaitLimit = 500;

    logic        clk;
    logic        rstN;
    logic        byteValid;
    instrByte_t  byteData;
    logic        byteCredit;
    logic        opValid;
    aluOp_t      opAlu;
    logic        opUseIy;
    instrByte_t  opDisp;
    logic        opCredit;

    // Ops packed as {useIy, alu, disp}.
    logic [11:0] expQ [$];
    logic [11:0] fileChk [$];
    int          bytesSent;
    int          creditsBack;
    int          opsSeen;
    int          creditsGiven;

    // Reference state is 0 when idle, 1 after a prefix and 2 one byte later.
    int          refState;
    logic        refIy;
    logic        refMatch;
    aluOp_t      refOp;

    ixAluDecodeTop ixAluDecodeTop_inst (
        .clk        (clk),
        .rstN       (rstN),
        .byteValid  (byteValid),
        .byteData   (byteData),
        .byteCredit (byteCredit),
        .opValid    (opValid),
        .opAlu      (opAlu),
        .opUseIy    (opUseIy),
        .opDisp     (opDisp),
        .opCredit   (opCredit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkAlu(input aluOp_t act, input aluOp_t exp, input string name);
        if (act !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, act, exp);
            stopWithFailure("ALU op differs");
        end
    endtask

    task automatic checkByte(input instrByte_t act, input instrByte_t exp, input string name);
        if (act !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
            stopWithFailure("byte value differs");
        end
    endtask

    task automatic checkBit(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, act, exp);
            stopWithFailure("bit value differs");
        end
    endtask

    // Prefix, then 10xxx110, then the displacement.
    task automatic modelByte(input instrByte_t b);
        if (refState == 2 && refMatch) begin
            expQ.push_back({refIy, refOp, b});
            fileChk.push_back({refIy, refOp, b});
            refState = 0;
            refMatch = 1'b0;
        end else if (b == 8'hDD || b == 8'hFD) begin
            refState = 1;
            refIy    = (b == 8'hFD);
            refMatch = 1'b0;
        end else begin
            refMatch = (b[7:6] == 2'b10) && (b[2:0] == 3'b110);
            refOp    = aluOp_t'(b[5:3]);
            refState = (refState == 1) ? 2 : 0;
        end
    endtask

    task automatic sendByte(input instrByte_t b);
        int waitCnt;
        waitCnt = 0;
        while (bytesSent - creditsBack >= QueueDepth) begin
            @(posedge clk);
            waitCnt++;
            if (waitCnt > WaitLimit) stopWithFailure("timeout waiting for a byte credit");
        end
        repeat ($urandom % 4) @(posedge clk);
        @(posedge clk);
        #5;
        byteValid = 1'b1;
        byteData  = b;
        bytesSent++;
        modelByte(b);
        @(posedge clk);
        #5;
        byteValid = 1'b0;
    endtask

    task automatic returnCredit();
        int waitCnt;
        waitCnt = 0;
        while (opsSeen <= creditsGiven) begin
            @(posedge clk);
            waitCnt++;
            if (waitCnt > WaitLimit) stopWithFailure("timeout waiting for an op to credit");
        end
        @(posedge clk);
        #5;
        opCredit = 1'b1;
        creditsGiven++;
        @(posedge clk);
        #5;
        opCredit = 1'b0;
    endtask

    task automatic checkFileOp(input int a, input int iy, input int d);
        logic [11:0] got;
        if (fileChk.size() == 0) stopWithFailure("testdata expects an op the stream does not form");
        got = fileChk.pop_front();
        checkAlu(aluOp_t'(got[10:8]), aluOp_t'(a[2:0]), "testdata opAlu");
        checkBit(got[11], iy[0], "testdata opUseIy");
        checkByte(got[7:0], instrByte_t'(d), "testdata opDisp");
    endtask

    initial begin : opMonitor
        logic [11:0] exp;
        forever begin
            @(negedge clk);
            if (rstN && byteCredit) creditsBack++;
            if (rstN && opValid) begin
                if (expQ.size() == 0) stopWithFailure("op issued with no op expected");
                exp = expQ.pop_front();
                checkAlu(opAlu, aluOp_t'(exp[10:8]), "opAlu");
                checkBit(opUseIy, exp[11], "opUseIy");
                checkByte(opDisp, exp[7:0], "opDisp");
                opsSeen++;
                if (opsSeen - creditsGiven > OpCredits) begin
                    stopWithFailure("more ops issued than op credits allow");
                end
            end
        end
    end

    initial begin : mainFlow
        int    fd;
        int    code;
        byte   cmd;
        int    value;
        int    a;
        int    iy;
        int    d;
        int    waitCnt;
        string rest;
        void'($urandom(32'hf166647b));
        rstN = 1'b0;
        byteValid = 1'b0;
        byteData = '0;
        opCredit = 1'b0;
        bytesSent = 0;
        creditsBack = 0;
        opsSeen = 0;
        creditsGiven = 0;
        refState = 0;
        refIy = 1'b0;
        refMatch = 1'b0;
        refOp = aluAdd;
        repeat (3) begin
            @(posedge clk);
            #5;
            checkBit(opValid, 1'b0, "opValid");
            checkBit(byteCredit, 1'b0, "byteCredit");
        end
        rstN = 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkBit(opValid, 1'b0, "opValid");
            checkBit(byteCredit, 1'b0, "byteCredit");
        end

        fd = $fopen("ixAluDecode_testdata.txt", "r");
        if (fd == 0) stopWithFailure("cannot open the testdata file");
        code = $fscanf(fd, " %c", cmd);
        while (code == 1) begin
            case (cmd)
                "#": code = $fgets(rest, fd);
                "B": begin
                    code = $fscanf(fd, "%h", value);
                    sendByte(instrByte_t'(value));
                end
                "C": returnCredit();
                "W": begin
                    code = $fscanf(fd, "%d", value);
                    repeat (value) @(posedge clk);
                end
                "E": begin
                    code = $fscanf(fd, "%h %h %h", a, iy, d);
                    checkFileOp(a, iy, d);
                end
                default: stopWithFailure("unknown command in the testdata file");
            endcase
            code = $fscanf(fd, " %c", cmd);
        end
        $fclose(fd);

        waitCnt = 0;
        while (expQ.size() != 0 || creditsBack != bytesSent) begin
            @(posedge clk);
            waitCnt++;
            if (waitCnt > WaitLimit) stopWithFailure("timeout waiting for ops and byte credits");
        end
        repeat (2) @(posedge clk);
        if (fileChk.size() == 0 && creditsBack == bytesSent) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stopWithFailure("unmatched ops or byte credits at end of test");
        end
    end

endmodule

`default_nettype wire

// ==== ixAluDecode_testdata.txt ====
# B hh: send byte hh. C: return one op credit. W n: idle n cycles.
# E a i dd: expected op with ALU code a, useIy i, displacement dd (hex).
W 3
# All eight ops with both prefixes.
B DD B 86 B 05 E 0 0 05 C
B FD B 8E B 11 E 1 1 11 C
B DD B 96 B 22 E 2 0 22 C
B FD B 9E B 33 E 3 1 33 C
B DD B A6 B 44 E 4 0 44 C
B FD B AE B 55 E 5 1 55 C
B DD B B6 B 66 E 6 0 66 C
B FD B BE B 77 E 7 1 77 C
# Unprefixed ALU opcodes and plain bytes.
B 86 B BE B 00 B 01 B 02
# Prefixed non-ALU opcode, then fresh decode.
B DD B 7E B 86 B 12
B DD B 7E B FD B 96 B 0A E 2 1 0A C
# Later prefix wins.
B DD B FD B 86 B 3C E 0 1 3C C
# Prefix bytes used as displacement.
B FD B B6 B DD E 6 1 DD C
B 86 B 01
B DD B 9E B FD E 3 0 FD C
B 8E B 02
# Output back-pressure with credits withheld.
B DD B 86 B 10 E 0 0 10
B FD B 8E B 20 E 1 1 20
B DD B 96 B 30 E 2 0 30
B FD B 9E B 40 E 3 1 40
W 20
C C C C
B FD B AE B 5A E 5 1 5A C
W 5

// ==== files.f ====
ixDecodePkg.sv
byteQueue.sv
prefixTracker.sv
aluOpDecoder.sv
opIssue.sv
ixAluDecodeTop.sv
ixAluDecodeTb_asserts.sv
ixAluDecodeTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module ixAluDecodeTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

out=$(./obj_dir/VixAluDecodeTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
    exit 0
fi
exit 1
